/* common/ppu_pkg.sv */
// Shared types and constants for the background picture processor
// Beam positions use 9 bits and the pre-render line is scanline 9'h1FF

package ppu_pkg;

  // CPU visible register map, OAM slots kept for address compatibility
  typedef enum logic [2:0] {
    REG_CTRL     = 3'd0,
    REG_MASK     = 3'd1,
    REG_STATUS   = 3'd2,
    REG_OAM_ADDR = 3'd3,   // No OAM in this design
    REG_OAM_DATA = 3'd4,   // No OAM in this design
    REG_SCROLL   = 3'd5,
    REG_ADDR     = 3'd6,
    REG_DATA     = 3'd7
  } reg_addr_e;

  typedef struct packed {
    reg_addr_e  ain;
    logic [7:0] din;
    logic       read;
    logic       write;
  } cpu_bus_t;

  typedef struct packed {
    logic [13:0] addr;
    logic        rd;
    logic        wr;
    logic [7:0]  wdata;
  } vram_req_t;

  typedef struct packed {
    logic [8:0] scanline;   // All ones on the pre-render line
    logic [8:0] cycle;
  } beam_pos_t;

  typedef struct packed {
    beam_pos_t pos;
    logic      rendering;
    logic      pre_render;
    logic      end_of_line;
    logic      last_group;        // Cycles 336 and up
    logic      entering_vblank;   // Last cycle of line 240
    logic      exiting_vblank;    // Last cycle of the last vblank line
  } timing_t;

  // Bit order matches the 15-bit VRAM address register
  typedef struct packed {
    logic [2:0] fine_y;
    logic       nt_y;
    logic       nt_x;
    logic [4:0] coarse_y;
    logic [4:0] coarse_x;
  } loopy_t;

  typedef struct packed {
    logic nmi_enable;
    logic bg_patt;
    logic incr32;
  } ctrl_t;

  typedef struct packed {
    logic grayscale;
    logic bg_clip;
    logic bg_enable;
  } mask_t;

  typedef struct packed {
    logic [1:0] attr;
    logic [1:0] pat;
  } bg_pixel_t;

  localparam logic [8:0] LINE_LAST_CYCLE  = 9'd340;
  localparam logic [8:0] POST_RENDER_LINE = 9'd240;
  localparam logic [5:0] PAL_PAGE         = 6'h3F;   // Address bits 13..8 of palette space

  // Data phases inside the eight-cycle tile slot
  localparam logic [2:0] PHASE_NAME = 3'd1;
  localparam logic [2:0] PHASE_ATTR = 3'd3;
  localparam logic [2:0] PHASE_PAT0 = 3'd5;
  localparam logic [2:0] PHASE_PAT1 = 3'd7;

endpackage

/* logic/ppu_timing.sv */
// Beam counters: 341 cycles per line, 242 + VBLANK_LINES lines per frame
// Odd frames drop one pre-render cycle only while the background renders

`timescale 1ns/1ps

module ppu_timing #(
  parameter int VBLANK_LINES = 20
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              bg_enable,
  output ppu_pkg::timing_t  timing
);

  localparam logic [8:0] PRE_RENDER_LINE  = 9'h1FF;
  localparam logic [8:0] LAST_VBLANK_LINE = ppu_pkg::POST_RENDER_LINE + 9'(VBLANK_LINES);

  logic [8:0] cycle;
  logic [8:0] scanline;
  logic       vblank;
  logic       odd_frame;
  logic       pre_render;
  logic       rendering;
  logic       short_line;
  logic       end_of_line;
  logic       last_group;
  logic       entering_vblank;
  logic       exiting_vblank;

  assign pre_render = scanline == PRE_RENDER_LINE;
  assign rendering  = bg_enable && !vblank && scanline != ppu_pkg::POST_RENDER_LINE;
  assign short_line = pre_render && odd_frame && rendering;   // Skipped cycle
  assign last_group = cycle[8:3] == ppu_pkg::LINE_LAST_CYCLE[8:3];
  assign end_of_line = cycle == (short_line ? ppu_pkg::LINE_LAST_CYCLE - 9'd1
                                            : ppu_pkg::LINE_LAST_CYCLE);

  // Vblank edges fall on the last cycle of a line
  assign entering_vblank = end_of_line && scanline == ppu_pkg::POST_RENDER_LINE;
  assign exiting_vblank  = end_of_line && scanline == LAST_VBLANK_LINE;

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle     <= '0;
      scanline  <= '0;
      vblank    <= 1'b0;
      odd_frame <= 1'b0;
    end else begin
      cycle <= end_of_line ? 9'd0 : cycle + 9'd1;
      if (end_of_line) begin
        scanline <= exiting_vblank ? PRE_RENDER_LINE : scanline + 9'd1;   // 1FF wraps to 0
      end
      if (entering_vblank) begin
        vblank <= 1'b1;
      end else if (exiting_vblank) begin
        vblank <= 1'b0;
      end
      if (exiting_vblank) odd_frame <= ~odd_frame;   // Frame parity for the short line
    end
  end

  assign timing = '{
    pos:             '{scanline: scanline, cycle: cycle},
    rendering:       rendering,
    pre_render:      pre_render,
    end_of_line:     end_of_line,
    last_group:      last_group,
    entering_vblank: entering_vblank,
    exiting_vblank:  exiting_vblank
  };

endmodule

/* logic/ppu_regs.sv */
// Control, mask and status registers with the vblank NMI flag
// Read data is combinational from ain; status reads clear the flag on the edge

`timescale 1ns/1ps

module ppu_regs (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::cpu_bus_t  cpu,
  input  ppu_pkg::timing_t   timing,
  input  logic [7:0]         vram_latch,
  input  logic               pal_sel,
  input  logic [5:0]         color,
  output ppu_pkg::ctrl_t     ctrl,
  output ppu_pkg::mask_t     mask,
  output logic               nmi,
  output logic [7:0]         dout
);

  logic nmi_occurred;   // Vblank seen and not yet acknowledged
  logic status_rd;

  assign status_rd = cpu.read && cpu.ain == ppu_pkg::REG_STATUS;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl         <= '0;
      mask         <= '0;
      nmi_occurred <= 1'b0;
    end else begin
      if (cpu.write) begin
        case (cpu.ain)
          ppu_pkg::REG_CTRL: begin
            ctrl.nmi_enable <= cpu.din[7];
            ctrl.bg_patt    <= cpu.din[4];   // Background pattern table half
            ctrl.incr32     <= cpu.din[2];
          end
          ppu_pkg::REG_MASK: begin
            mask.grayscale <= cpu.din[0];
            mask.bg_clip   <= cpu.din[1];   // 1 shows the leftmost 8 pixels
            mask.bg_enable <= cpu.din[3];
          end
          default: begin
          end
        endcase
      end

      // Later assignments win, so a status read beats the set
      if (timing.exiting_vblank) nmi_occurred <= 1'b0;
      if (timing.entering_vblank) nmi_occurred <= 1'b1;
      if (status_rd) nmi_occurred <= 1'b0;
    end
  end

  assign nmi = nmi_occurred && ctrl.nmi_enable;

  always_comb begin
    if (cpu.ain == ppu_pkg::REG_STATUS) begin
      dout = {nmi_occurred, 7'b0};   // Sprite status bits stay zero
    end else if (pal_sel) begin
      dout = {2'b00, color};          // Palette reads bypass the buffer
    end else begin
      dout = vram_latch;
    end
  end

endmodule

/* bg/bg_scroll.sv */
// Scroll state: temporary and current VRAM address, fine X and write toggle
// Render-time updates follow the fixed fetch schedule; CPU writes win on collision

`timescale 1ns/1ps

module bg_scroll (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::cpu_bus_t  cpu,
  input  logic               incr32,
  input  ppu_pkg::timing_t   timing,
  output ppu_pkg::loopy_t    v,
  output logic [2:0]         fine_x
);

  localparam logic [8:0] CYC_VERT_INC   = 9'd251;
  localparam logic [8:0] CYC_HORIZ_COPY = 9'd256;
  localparam logic [8:0] CYC_FULL_COPY  = 9'd304;
  localparam logic [8:0] CYC_PREFETCH   = 9'd320;   // Next-line tile fetches
  localparam logic [8:0] CYC_PREFETCH_END = 9'd336;

  ppu_pkg::loopy_t t;   // Temporary address
  logic            w;   // First or second write
  logic [8:0]      cycle;
  logic            coarse_x_step;
  logic            data_access;

  assign cycle = timing.pos.cycle;
  assign coarse_x_step = cycle[2:0] == ppu_pkg::PHASE_ATTR &&
                         (cycle < CYC_HORIZ_COPY ||
                          (cycle >= CYC_PREFETCH && cycle < CYC_PREFETCH_END));
  assign data_access = (cpu.read || cpu.write) && cpu.ain == ppu_pkg::REG_DATA;

  always_ff @(posedge clk) begin
    if (reset) begin
      t      <= '0;
      v      <= '0;
      fine_x <= '0;
      w      <= 1'b0;
    end else begin
      if (timing.rendering) begin
        if (coarse_x_step) begin
          v.coarse_x <= v.coarse_x + 5'd1;
          if (v.coarse_x == 5'd31) v.nt_x <= ~v.nt_x;   // Into the next table
        end
        if (cycle == CYC_VERT_INC) begin
          v.fine_y <= v.fine_y + 3'd1;
          if (v.fine_y == 3'd7) begin
            if (v.coarse_y == 5'd29) begin
              v.coarse_y <= 5'd0;
              v.nt_y     <= ~v.nt_y;
            end else begin
              v.coarse_y <= v.coarse_y + 5'd1;   // Rows 30, 31 wrap without toggle
            end
          end
        end
        if (cycle == CYC_HORIZ_COPY) begin
          v.nt_x     <= t.nt_x;
          v.coarse_x <= t.coarse_x;
        end
        if (cycle == CYC_FULL_COPY && timing.pre_render) v <= t;
      end

      if (cpu.write && cpu.ain == ppu_pkg::REG_CTRL) begin
        t.nt_y <= cpu.din[1];
        t.nt_x <= cpu.din[0];
      end else if (cpu.write && cpu.ain == ppu_pkg::REG_SCROLL) begin
        if (!w) begin
          t.coarse_x <= cpu.din[7:3];
          fine_x     <= cpu.din[2:0];
        end else begin
          t.coarse_y <= cpu.din[7:3];
          t.fine_y   <= cpu.din[2:0];
        end
        w <= ~w;
      end else if (cpu.write && cpu.ain == ppu_pkg::REG_ADDR) begin
        if (!w) begin
          t <= ppu_pkg::loopy_t'({1'b0, cpu.din[5:0], t[7:0]});   // High byte, bit 14 cleared
        end else begin
          t <= ppu_pkg::loopy_t'({t[14:8], cpu.din});
          v <= ppu_pkg::loopy_t'({t[14:8], cpu.din});
        end
        w <= ~w;
      end else if (cpu.read && cpu.ain == ppu_pkg::REG_STATUS) begin
        w <= 1'b0;
      end else if (data_access && !timing.rendering) begin
        v <= ppu_pkg::loopy_t'(v + (incr32 ? 15'd32 : 15'd1));   // Across or down
      end
    end
  end

endmodule

/* bg/bg_shifter.sv */
// Background tile capture and pixel shift pipes
// Expects VRAM data one cycle after each even-cycle fetch

`timescale 1ns/1ps

module bg_shifter (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::timing_t    timing,
  input  ppu_pkg::loopy_t     v,
  input  logic [2:0]          fine_x,
  input  logic [7:0]          vram_din,
  input  logic                bg_clip,
  input  logic                bg_enable,
  output logic [7:0]          name_byte,
  output ppu_pkg::bg_pixel_t  pixel
);

  logic [7:0]  pat0_byte;
  logic [1:0]  attr_bits;    // Palette select for the fetched tile
  logic [1:0]  quadrant;
  logic [15:0] pipe_pat0;
  logic [15:0] pipe_pat1;
  logic [8:0]  pipe_attr0;
  logic [8:0]  pipe_attr1;
  logic [2:0]  phase;
  logic [3:0]  idx;
  logic        show_bg;

  // Pipes shift toward bit 0, so bit 7 of the byte must land first
  function automatic logic [7:0] bit_rev(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7 - i];
    end
    return r;
  endfunction

  assign phase = timing.pos.cycle[2:0];

  always_comb begin
    case ({v.coarse_y[1], v.coarse_x[1]})   // 2x2 tile quadrant
      2'b00:   quadrant = vram_din[1:0];
      2'b01:   quadrant = vram_din[3:2];
      2'b10:   quadrant = vram_din[5:4];
      default: quadrant = vram_din[7:6];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      name_byte  <= '0;
      pat0_byte  <= '0;
      attr_bits  <= '0;
      pipe_pat0  <= '0;
      pipe_pat1  <= '0;
      pipe_attr0 <= '0;
      pipe_attr1 <= '0;
    end else begin
      case (phase)
        ppu_pkg::PHASE_NAME: name_byte <= vram_din;
        ppu_pkg::PHASE_ATTR: attr_bits <= quadrant;
        ppu_pkg::PHASE_PAT0: pat0_byte <= vram_din;
        default: begin
        end
      endcase
      if (!timing.last_group) begin
        pipe_pat0[14:0]  <= pipe_pat0[15:1];
        pipe_pat1[14:0]  <= pipe_pat1[15:1];
        pipe_attr0[7:0]  <= pipe_attr0[8:1];
        pipe_attr1[7:0]  <= pipe_attr1[8:1];
        if (phase == ppu_pkg::PHASE_PAT1) begin   // Plane 1 taken straight off the bus
          pipe_pat0[15:8] <= bit_rev(pat0_byte);
          pipe_pat1[15:8] <= bit_rev(vram_din);
          pipe_attr0[8]   <= attr_bits[0];
          pipe_attr1[8]   <= attr_bits[1];
        end
      end
    end
  end

  assign idx     = {1'b0, fine_x};
  assign show_bg = (bg_clip || timing.pos.cycle[7:3] != 5'd0) && bg_enable;   // Left 8 clip
  assign pixel   = '{
    attr: {pipe_attr1[idx], pipe_attr0[idx]},
    pat:  show_bg ? {pipe_pat1[idx], pipe_pat0[idx]} : 2'b00
  };

endmodule

/* logic/vram_port.sv */
// VRAM request generator and buffered read latch
// Render fetches issue on even cycles; palette-space CPU accesses never reach VRAM

`timescale 1ns/1ps

module vram_port (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::cpu_bus_t   cpu,
  input  ppu_pkg::timing_t    timing,
  input  ppu_pkg::loopy_t     v,
  input  logic [7:0]          name_byte,
  input  ppu_pkg::bg_pixel_t  pixel,
  input  logic                bg_patt,
  input  logic [7:0]          vram_din,
  output ppu_pkg::vram_req_t  vram,
  output logic                pal_sel,
  output logic [7:0]          vram_latch,
  output logic [4:0]          pal_addr,
  output logic                pal_we
);

  logic        cpu_data;
  logic        rd;
  logic        wr;
  logic        rd_d;           // Read issued last cycle
  logic [13:0] render_addr;
  logic [8:0]  cycle;

  assign cycle    = timing.pos.cycle;
  assign cpu_data = cpu.ain == ppu_pkg::REG_DATA;
  assign pal_sel  = v[13:8] == ppu_pkg::PAL_PAGE;

  always_comb begin
    case (cycle[2:1])
      2'd0:    render_addr = {2'b10, v[11:0]};   // Name table
      2'd1:    render_addr = {2'b10, v.nt_y, v.nt_x, 4'b1111,
                              v.coarse_y[4:2], v.coarse_x[4:2]};   // Attribute byte
      default: render_addr = {1'b0, bg_patt, name_byte, cycle[1], v.fine_y};   // Plane 0 or 1
    endcase
  end

  assign rd = (cpu.read && cpu_data && !pal_sel) ||
              (timing.rendering && !cycle[0] && !timing.end_of_line);
  assign wr = cpu.write && cpu_data && !pal_sel && !timing.rendering;

  assign vram = '{
    addr:  timing.rendering ? render_addr : v[13:0],
    rd:    rd,
    wr:    wr,
    wdata: cpu.din
  };

  assign pal_we   = cpu.write && cpu_data && pal_sel;
  assign pal_addr = timing.rendering ? {1'b0, pixel} : (pal_sel ? v[4:0] : 5'd0);

  always_ff @(posedge clk) begin
    if (reset) rd_d <= 1'b0;
    else rd_d <= rd;
  end

  // Data shows up one cycle after the request
  always_ff @(posedge clk) begin
    if (rd_d) vram_latch <= vram_din;
  end

endmodule

/* logic/palette_ram.sv */
// 32 x 6 palette, combinational read and write on the edge
// Entries with low bits zero share entry 0; writes to 4, 8, 12 and mirrors are dropped

`timescale 1ns/1ps

module palette_ram (
  input  logic       clk,
  input  logic [4:0] addr,
  input  logic [5:0] din,
  input  logic       we,
  input  logic       grayscale,
  output logic [5:0] color
);

  logic [5:0] mem [32];
  logic [4:0] eff_addr;   // After backdrop mirroring
  logic [5:0] raw;

  assign eff_addr = (addr[1:0] == 2'b00) ? 5'd0 : addr;
  assign raw      = mem[eff_addr];
  assign color    = grayscale ? {raw[5:4], 4'b0000} : raw;   // Keep luma column only

  always_ff @(posedge clk) begin
    if (we && !(addr[3:2] != 2'b00 && addr[1:0] == 2'b00)) begin
      mem[eff_addr] <= din;
    end
  end

endmodule

/* logic/ppu_top.sv */
// Background-only picture processor, one pixel per clk, no clock enable
// VRAM data must arrive on vram_din one cycle after each vram.rd

`timescale 1ns/1ps

module ppu_top #(
  parameter int VBLANK_LINES = 20
) (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::cpu_bus_t   cpu,
  output logic [7:0]          dout,
  output logic                nmi,
  output ppu_pkg::vram_req_t  vram,
  input  logic [7:0]          vram_din,
  output logic [5:0]          color,
  output ppu_pkg::beam_pos_t  beam
);

  ppu_pkg::timing_t   timing;
  ppu_pkg::ctrl_t     ctrl;
  ppu_pkg::mask_t     mask;
  ppu_pkg::loopy_t    v;          // Current VRAM address
  ppu_pkg::bg_pixel_t pixel;
  logic [2:0]         fine_x;
  logic [7:0]         name_byte;
  logic [7:0]         vram_latch;  // Buffered read data
  logic               pal_sel;
  logic [4:0]         pal_addr;
  logic               pal_we;

  assign beam = timing.pos;

  ppu_timing #(.VBLANK_LINES(VBLANK_LINES)) u_timing (
    .clk(clk), .reset(reset), .bg_enable(mask.bg_enable), .timing(timing)
  );

  ppu_regs u_regs (
    .clk(clk), .reset(reset), .cpu(cpu), .timing(timing),
    .vram_latch(vram_latch), .pal_sel(pal_sel), .color(color),
    .ctrl(ctrl), .mask(mask), .nmi(nmi), .dout(dout)
  );

  bg_scroll u_scroll (
    .clk(clk), .reset(reset), .cpu(cpu), .incr32(ctrl.incr32),
    .timing(timing), .v(v), .fine_x(fine_x)
  );

  bg_shifter u_shifter (
    .clk(clk), .reset(reset), .timing(timing), .v(v), .fine_x(fine_x),
    .vram_din(vram_din), .bg_clip(mask.bg_clip), .bg_enable(mask.bg_enable),
    .name_byte(name_byte), .pixel(pixel)
  );

  vram_port u_vram_port (
    .clk(clk), .reset(reset), .cpu(cpu), .timing(timing), .v(v),
    .name_byte(name_byte), .pixel(pixel), .bg_patt(ctrl.bg_patt),
    .vram_din(vram_din), .vram(vram), .pal_sel(pal_sel),
    .vram_latch(vram_latch), .pal_addr(pal_addr), .pal_we(pal_we)
  );

  palette_ram u_palette (
    .clk(clk), .addr(pal_addr), .din(cpu.din[5:0]), .we(pal_we),
    .grayscale(mask.grayscale), .color(color)
  );

endmodule

/* dv/ppu_assert.sv */
// Bus and vblank rules checked on the top level, bound from the testbench
// VBLANK_LINES must match the bound instance

`timescale 1ns/1ps

module ppu_assert #(
  parameter int VBLANK_LINES = 20
) (
  input logic               clk,
  input logic               reset,
  input ppu_pkg::vram_req_t vram,
  input logic               bg_enable,
  input logic               nmi,
  input ppu_pkg::beam_pos_t beam
);

  localparam logic [8:0] LAST_VBLANK = 9'(240 + VBLANK_LINES);

  logic rendering;   // Visible and pre-render lines with the background on

  assign rendering = bg_enable && (beam.scanline < 9'd240 || beam.scanline == 9'h1FF);

  // One VRAM access kind per cycle
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(vram.rd && vram.wr))
    else $error("VRAM read and write strobes high together");

  a_no_render_write: assert property (@(posedge clk) disable iff (reset)
    rendering |-> !vram.wr)
    else $error("VRAM write during rendering");

  // Lines 241 up to the last vblank line only
  a_nmi_in_vblank: assert property (@(posedge clk) disable iff (reset)
    nmi |-> (beam.scanline > 9'd240 && beam.scanline <= LAST_VBLANK))
    else $error("nmi high outside vblank");

endmodule

/* dv/ppu_tb_tasks.svh */
// LFSR stimulus, CPU bus tasks and bounded waits for the testbench
// Tasks start and end 10 ns after a rising edge

`ifndef PPU_TB_TASKS_SVH
`define PPU_TB_TASKS_SVH

// Galois LFSR, taps 16'hB400, one step per bit taken
function automatic logic [15:0] rand_bits(input int n);
  logic [15:0] r;
  logic        b;
  r = '0;
  for (int i = 0; i < n; i++) begin
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hB400;
    r    = {r[14:0], b};
  end
  return r;
endfunction

task automatic check_hex(input string sig, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    $display("** Error: %s = %h, expected %h", sig, got, exp);
    errors++;
  end
endtask

task automatic bus_write(input ppu_pkg::reg_addr_e a, input logic [7:0] d);
  @(posedge clk);
  #10;
  cpu = '{ain: a, din: d, read: 1'b0, write: 1'b1};
  @(posedge clk);
  #10;
  cpu = '{ain: ppu_pkg::REG_CTRL, din: 8'h00, read: 1'b0, write: 1'b0};
endtask

task automatic bus_read(input ppu_pkg::reg_addr_e a, output logic [7:0] d);
  @(posedge clk);
  #10;
  cpu = '{ain: a, din: 8'h00, read: 1'b1, write: 1'b0};
  #70 d = dout;   // Combinational, settled before the edge
  @(posedge clk);
  #10;
  cpu = '{ain: ppu_pkg::REG_CTRL, din: 8'h00, read: 1'b0, write: 1'b0};
endtask

// Status read first so the write toggle starts at the high byte
task automatic set_vaddr(input logic [13:0] a);
  logic [7:0] d;
  bus_read(ppu_pkg::REG_STATUS, d);
  bus_write(ppu_pkg::REG_ADDR, {2'b00, a[13:8]});
  bus_write(ppu_pkg::REG_ADDR, a[7:0]);
endtask

task automatic wait_beam(input logic [8:0] line, input logic [8:0] cyc, input int limit);
  int n;
  n = 0;
  while (!(beam.scanline == line && beam.cycle == cyc)) begin
    if (n >= limit) begin
      $display("timeout: beam never reached line %0d cycle %0d", line, cyc);
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);
    #10;
    n++;
  end
endtask

// Called at line 241 cycle 0, returns at the next one
task automatic frame_length(output int len);
  len = 0;
  do begin
    @(posedge clk);
    #10;
    len++;
  end while (!(beam.scanline == 9'd241 && beam.cycle == 9'd0) && len < 100000);
  if (len >= 100000) begin
    $display("timeout: no frame start within 100000 cycles");
    timed_out = 1'b1;
  end
endtask

`endif

/* dv/ppu_tb.sv */
// Testbench for the background picture processor with VRAM and palette models
// Frame checks assume VBLANK_LINES of 20, i.e. 262 lines per frame

`timescale 1ns/1ps

module ppu_tb;

  localparam int FRAME = 341 * 262;

  logic               clk;
  logic               reset;
  ppu_pkg::cpu_bus_t  cpu;
  logic [7:0]         dout;
  logic               nmi;
  ppu_pkg::vram_req_t vram;
  logic [7:0]         vram_din;
  logic [5:0]         color;
  ppu_pkg::beam_pos_t beam;

  logic [7:0]  vmem [16384];   // VRAM model
  logic [5:0]  pal_model [32];
  logic [21:0] wr_log [$];     // Address and data of each VRAM write
  logic [15:0] lfsr;
  logic        timed_out;
  int          checks, errors, tests_run, tests_failed;

  ppu_top #(.VBLANK_LINES(20)) u_ppu_top (
    .clk(clk), .reset(reset), .cpu(cpu), .dout(dout), .nmi(nmi),
    .vram(vram), .vram_din(vram_din), .color(color), .beam(beam)
  );

  bind ppu_top ppu_assert #(.VBLANK_LINES(VBLANK_LINES)) u_assert (
    .clk(clk), .reset(reset), .vram(vram), .bg_enable(mask.bg_enable),
    .nmi(nmi), .beam(beam)
  );

  `include "ppu_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Sample the request mid-cycle, answer 10 ns after the next edge
  always @(negedge clk) begin
    if (vram.wr) begin
      vmem[vram.addr] = vram.wdata;
      wr_log.push_back({vram.addr, vram.wdata});
    end
    if (vram.rd) begin
      logic [13:0] a;
      a = vram.addr;
      @(posedge clk);
      #10 vram_din = vmem[a];
    end
  end

  // Backdrop mirror on low bits zero, entries 4, 8, 12 and mirrors not writable
  function automatic logic [4:0] pal_index(input logic [4:0] a);
    return (a[1:0] == 2'b00) ? 5'd0 : a;
  endfunction

  task automatic pal_store(input logic [4:0] a, input logic [5:0] d);
    if (!(a[3:2] != 2'b00 && a[1:0] == 2'b00)) pal_model[pal_index(a)] = d;
  endtask

  task automatic close_test(input string name, input int err_start);
    tests_run++;
    if (errors != err_start || timed_out) begin
      tests_failed++;
      $display("test %s failed", name);
    end else begin
      $display("test %s ok", name);
    end
  endtask

  task automatic write_vram_burst();
    logic [13:0] a;
    logic [7:0]  d;
    logic [21:0] exp_q [$];
    logic        inc32;
    inc32 = rand_bits(1) != 16'd0;
    bus_write(ppu_pkg::REG_CTRL, {5'b0, inc32, 2'b00});
    a = 14'(rand_bits(13));   // Stays clear of palette space
    set_vaddr(a);
    wr_log.delete();
    for (int i = 0; i < 16; i++) begin
      d = 8'(rand_bits(8));
      bus_write(ppu_pkg::REG_DATA, d);
      exp_q.push_back({a, d});
      a = a + (inc32 ? 14'd32 : 14'd1);
    end
    check_hex("vram.wr count", 16'(wr_log.size()), 16'd16);
    for (int i = 0; i < 16 && i < wr_log.size(); i++) begin
      check_hex("vram.addr", 16'(wr_log[i][21:8]), 16'(exp_q[i][21:8]));
      check_hex("vram.wdata", 16'(wr_log[i][7:0]), 16'(exp_q[i][7:0]));
    end
  endtask

  task automatic read_vram_buffered();
    logic [13:0] a;
    logic [13:0] prev;
    logic [7:0]  d;
    logic        inc32;
    inc32 = rand_bits(1) != 16'd0;
    bus_write(ppu_pkg::REG_CTRL, {5'b0, inc32, 2'b00});
    a = 14'(rand_bits(13));
    set_vaddr(a);
    bus_read(ppu_pkg::REG_DATA, d);   // Stale buffer, primes the first address
    prev = a;
    a = a + (inc32 ? 14'd32 : 14'd1);
    for (int i = 0; i < 12; i++) begin
      bus_read(ppu_pkg::REG_DATA, d);
      check_hex("dout", 16'(d), 16'(vmem[prev]));
      prev = a;
      a = a + (inc32 ? 14'd32 : 14'd1);
    end
  endtask

  task automatic palette_roundtrip();
    logic [4:0] a;
    logic [7:0] d;
    logic [5:0] m;
    bus_write(ppu_pkg::REG_CTRL, 8'h00);
    bus_write(ppu_pkg::REG_MASK, 8'h00);
    set_vaddr(14'h3F00);
    for (int i = 0; i < 32; i++) begin   // Fill every entry in order
      d = 8'(rand_bits(8));
      bus_write(ppu_pkg::REG_DATA, d);
      pal_store(5'(i), d[5:0]);
    end
    for (int i = 0; i < 16; i++) begin
      a = 5'(rand_bits(5));
      d = 8'(rand_bits(8));
      set_vaddr({9'h1F8, a} | 14'h3F00);
      bus_write(ppu_pkg::REG_DATA, d);
      pal_store(a, d[5:0]);
    end
    for (int i = 0; i < 24; i++) begin
      a = 5'(rand_bits(5));
      bus_write(ppu_pkg::REG_MASK, {7'b0, i[0]});   // Grayscale every other read
      set_vaddr(14'h3F00 | {9'd0, a});
      bus_read(ppu_pkg::REG_DATA, d);
      m = pal_model[pal_index(a)];
      check_hex("dout", 16'(d), 16'({2'b00, i[0] ? {m[5:4], 4'b0000} : m}));
    end
    bus_write(ppu_pkg::REG_MASK, 8'h00);
  endtask

  task automatic vblank_and_frames();
    logic [7:0] d;
    int         n, f0, f1, f2;
    bus_write(ppu_pkg::REG_MASK, 8'h00);
    bus_write(ppu_pkg::REG_CTRL, 8'h80);   // NMI enable
    wait_beam(9'd0, 9'd0, 2 * FRAME);
    if (timed_out) return;
    n = 0;
    while (!nmi && n < 2 * FRAME) begin
      @(posedge clk);
      #10;
      n++;
    end
    if (!nmi) begin
      $display("timeout: nmi never rose");
      timed_out = 1'b1;
      return;
    end
    check_hex("beam.scanline", 16'(beam.scanline), 16'd241);
    checks++;
    assert (beam.cycle <= 9'd1) else begin
      $display("nmi rose late in line 241, at cycle %0d", beam.cycle);
      errors++;
    end
    bus_read(ppu_pkg::REG_STATUS, d);
    check_hex("dout[7]", 16'(d[7]), 16'd1);
    check_hex("nmi", 16'(nmi), 16'd0);
    bus_read(ppu_pkg::REG_STATUS, d);
    check_hex("dout[7]", 16'(d[7]), 16'd0);
    wait_beam(9'd241, 9'd0, 2 * FRAME);
    if (timed_out) return;
    frame_length(f0);
    check_hex("frame length", f0, FRAME);
    bus_write(ppu_pkg::REG_MASK, 8'h08);   // Background on
    wait_beam(9'd241, 9'd0, 2 * FRAME);
    if (timed_out) return;
    frame_length(f1);
    frame_length(f2);
    if (timed_out) return;
    check_hex("frame pair sum", f1 + f2, 2 * FRAME - 1);
    checks++;
    assert (f1 != f2) else begin
      $display("rendered frames did not alternate in length, both %0d cycles", f1);
      errors++;
    end
  endtask

  // Compare every pixel of lines 8..200 between two cycle bounds
  task automatic scan_color(input logic [8:0] c_lo, input logic [8:0] c_hi,
                            input logic [5:0] exp);
    int         n, bad;
    logic [5:0] first_bad;
    n = 0;
    bad = 0;
    first_bad = '0;
    wait_beam(9'd8, 9'd0, 2 * FRAME);
    if (timed_out) return;
    do begin
      if (beam.cycle >= c_lo && beam.cycle <= c_hi && color !== exp) begin
        if (bad == 0) first_bad = color;
        bad++;
      end
      @(posedge clk);
      #10;
      n++;
    end while (beam.scanline != 9'd201 && n < FRAME);
    if (beam.scanline != 9'd201) begin
      $display("timeout: line 201 not reached while scanning colors");
      timed_out = 1'b1;
    end
    check_hex("color", 16'(bad == 0 ? exp : first_bad), 16'(exp));
  endtask

  task automatic background_color();
    logic [7:0] d;
    bus_write(ppu_pkg::REG_MASK, 8'h00);
    for (int a = 0; a < 16384; a++) begin   // Plane 0 all ones, names and attributes 0
      vmem[a] = (a < 'h2000 && a[3] == 1'b0) ? 8'hFF : 8'h00;
    end
    d = 8'(rand_bits(8));
    set_vaddr(14'h3F01);
    bus_write(ppu_pkg::REG_DATA, d);
    pal_store(5'd1, d[5:0]);
    bus_write(ppu_pkg::REG_MASK, 8'h0A);   // Background on, left column shown
    scan_color(9'd16, 9'd240, pal_model[1]);
    if (timed_out) return;
    wr_log.delete();
    bus_write(ppu_pkg::REG_DATA, 8'hA5);   // Line 201 renders, VRAM stays untouched
    check_hex("vram.wr count", 16'(wr_log.size()), 16'd0);
    bus_write(ppu_pkg::REG_MASK, 8'h08);   // Left column clipped
    scan_color(9'd1, 9'd7, pal_model[0]);
    bus_write(ppu_pkg::REG_MASK, 8'h00);
  endtask

  initial begin
    int e;
    lfsr = 16'd36529;
    timed_out = 1'b0;
    checks = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    reset = 1'b1;
    vram_din = 8'h00;
    cpu = '{ain: ppu_pkg::REG_CTRL, din: 8'h00, read: 1'b0, write: 1'b0};
    for (int a = 0; a < 16384; a++) vmem[a] = 8'((a * 37) ^ (a >> 6) ^ 'h5A);
    repeat (4) @(posedge clk);
    #10 reset = 1'b0;

    e = errors;
    write_vram_burst();
    close_test("vram write", e);
    e = errors;
    if (!timed_out) read_vram_buffered();
    close_test("buffered vram read", e);
    e = errors;
    if (!timed_out) palette_roundtrip();
    close_test("palette", e);
    e = errors;
    if (!timed_out) vblank_and_frames();
    close_test("vblank nmi frame", e);
    e = errors;
    if (!timed_out) background_color();
    close_test("background color", e);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* ppu_top.f */
+incdir+dv
common/ppu_pkg.sv
logic/ppu_timing.sv
logic/ppu_regs.sv
bg/bg_scroll.sv
bg/bg_shifter.sv
logic/vram_port.sv
logic/palette_ram.sv
logic/ppu_top.sv
dv/ppu_assert.sv
dv/ppu_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ppu_tb
RTL_TOP  = ppu_top
FILELIST = ppu_top.f
BUILD    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
